// ==== hw/manycore_io_pkg.sv ====
package manycore_io_pkg;

  // array geometry, tiles on rows 1 and 2 below the io row
  localparam int NUM_TILES_X = 2;
  localparam int NUM_TILES_Y = 2;
  localparam int NUM_TILES   = NUM_TILES_X * NUM_TILES_Y;
  localparam int TILE_W      = $clog2(NUM_TILES);

  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int LOAD_ID_W = 5;
  localparam int X_W       = 1;
  localparam int Y_W       = 2;

  // io node coordinates, also the source of every loader packet
  localparam logic [X_W-1:0] IO_X_CORD = 1'b1;
  localparam logic [Y_W-1:0] IO_Y_CORD = 2'd0;

  // program image
  localparam int    PROG_WORDS = 16;
  localparam int    WORD_W     = $clog2(PROG_WORDS);
  localparam string PROG_FILE  = "program.hex";

  localparam logic [ADDR_W-1:0] PROG_BASE       = 16'h0400;
  localparam logic [ADDR_W-1:0] CSR_FREEZE_ADDR = 16'h2000;
  localparam logic [ADDR_W-1:0] FINISH_ADDR     = 16'head0;
  localparam logic [ADDR_W-1:0] FAIL_ADDR       = 16'head8;

  localparam int MAX_OUT_CREDITS = 8;
  localparam int CREDIT_W        = $clog2(MAX_OUT_CREDITS + 1);

  localparam int MAX_CYCLES = 2000;
  localparam int CYCLE_W    = $clog2(MAX_CYCLES + 1);

  localparam int DRAM_WORDS = 256;
  localparam int DRAM_IDX_W = $clog2(DRAM_WORDS);

  typedef enum logic [1:0] {
    OP_LOAD  = 2'b00,
    OP_STORE = 2'b01
  } mc_op_e;

  typedef struct packed {
    mc_op_e                 op;
    logic [ADDR_W-1:0]      addr;
    logic [DATA_W-1:0]      data;
    logic [X_W-1:0]         dst_x;
    logic [Y_W-1:0]         dst_y;
    logic [X_W-1:0]         src_x;
    logic [Y_W-1:0]         src_y;
    logic [LOAD_ID_W-1:0]   load_id;
  } mc_packet_t;

  typedef struct packed {
    mc_op_e                 op;
    logic [DATA_W-1:0]      data;
    logic [X_W-1:0]         dst_x;
    logic [Y_W-1:0]         dst_y;
    logic [LOAD_ID_W-1:0]   load_id;
  } mc_resp_t;

  typedef enum logic [1:0] {
    LD_IMAGE    = 2'd0,
    LD_UNFREEZE = 2'd1,
    LD_DONE     = 2'd2
  } loader_state_e;

endpackage

// ==== hw/spmd_loader.sv ====
`timescale 1ns/100ps

module spmd_loader
  import manycore_io_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       send_ok_i,
  output mc_packet_t pkt_o,
  output logic       v_o,
  output logic       done_o
);

  localparam logic [TILE_W-1:0] LAST_TILE = TILE_W'(NUM_TILES - 1);
  localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(PROG_WORDS - 1);

  logic [DATA_W-1:0] prog_rom [PROG_WORDS];

  loader_state_e     state_r;
  logic [TILE_W-1:0] tile_r;
  logic [WORD_W-1:0] word_r;
  logic              fire;

  initial
  begin
    $readmemh(PROG_FILE, prog_rom);
  end

  assign v_o    = send_ok_i && (state_r != LD_DONE);
  assign fire   = v_o && send_ok_i;
  assign done_o = (state_r == LD_DONE);

  // store packet for the current tile and word
  always_comb
  begin
    pkt_o         = '0;
    pkt_o.op      = OP_STORE;
    pkt_o.dst_x   = X_W'(tile_r % NUM_TILES_X);
    pkt_o.dst_y   = Y_W'(tile_r / NUM_TILES_X + 1);
    pkt_o.src_x   = IO_X_CORD;
    pkt_o.src_y   = IO_Y_CORD;
    pkt_o.addr    = CSR_FREEZE_ADDR;
    if (state_r == LD_IMAGE)
    begin
      pkt_o.addr = PROG_BASE + ADDR_W'(word_r);
      pkt_o.data = prog_rom[word_r];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= LD_IMAGE;
      tile_r  <= '0;
      word_r  <= '0;
    end
    else if (fire)
    begin
      case (state_r)
        LD_IMAGE:
        begin
          if (word_r == LAST_WORD)
          begin
            word_r <= '0;
            tile_r <= (tile_r == LAST_TILE) ? '0 : tile_r + 1'b1;
            // whole image sent, go back to tile 0 for unfreeze
            if (tile_r == LAST_TILE)
              state_r <= LD_UNFREEZE;
          end
          else
            word_r <= word_r + 1'b1;
        end
        LD_UNFREEZE:
        begin
          if (tile_r == LAST_TILE)
            state_r <= LD_DONE;
          else
            tile_r <= tile_r + 1'b1;
        end
        default:
          state_r <= LD_DONE;
      endcase
    end
  end

  // every image word has to come from the hex file
  a_pkt_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_o |-> !$isunknown(pkt_o));

endmodule

// ==== hw/out_credit_counter.sv ====
`timescale 1ns/100ps

module out_credit_counter
  import manycore_io_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic ready_i,
  input  logic send_i,
  input  logic credit_i,
  output logic send_ok_o
);

  logic [CREDIT_W-1:0] count_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      count_r <= CREDIT_W'(MAX_OUT_CREDITS);
    else
    begin
      // send and return in one cycle cancel out
      case ({send_i, credit_i})
        2'b10:   count_r <= count_r - 1'b1;
        2'b01:   count_r <= count_r + 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  assign send_ok_o = ready_i && (count_r != '0);

  // array never returns more credits than the loader spent
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_i |-> (count_r != CREDIT_W'(MAX_OUT_CREDITS)));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    send_i |-> (count_r != '0));

endmodule

// ==== hw/io_monitor.sv ====
`timescale 1ns/100ps

module io_monitor
  import manycore_io_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  mc_packet_t pkt_i,
  input  logic       v_i,
  output logic       credit_o,
  output logic       finish_o,
  output logic       success_o,
  output logic       timeout_o
);

  logic               is_store;
  logic               hit_finish;
  logic               hit_fail;
  logic [CYCLE_W-1:0] cycle_r;

  assign is_store   = v_i && (pkt_i.op == OP_STORE);
  assign hit_finish = is_store && (pkt_i.addr == FINISH_ADDR);
  assign hit_fail   = is_store && (pkt_i.addr == FAIL_ADDR);

  // every packet is consumed, one credit back per packet
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      credit_o <= 1'b0;
    else
      credit_o <= v_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_o  <= 1'b0;
      success_o <= 1'b0;
    end
    else if (!finish_o)
    begin
      // first finishing store decides the result
      if (hit_finish)
      begin
        finish_o  <= 1'b1;
        success_o <= 1'b1;
      end
      else if (hit_fail)
        finish_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cycle_r   <= '0;
      timeout_o <= 1'b0;
    end
    else
    begin
      if (cycle_r != CYCLE_W'(MAX_CYCLES))
        cycle_r <= cycle_r + 1'b1;
      // flag lands in the cycle the count reaches the limit
      if (!finish_o && (cycle_r == CYCLE_W'(MAX_CYCLES - 1)))
        timeout_o <= 1'b1;
    end
  end

  a_success_with_finish: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(success_o) |-> $rose(finish_o));

endmodule

// ==== hw/dram_model.sv ====
`timescale 1ns/100ps

module dram_model
  import manycore_io_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  mc_packet_t req_i,
  input  logic       v_i,
  output mc_resp_t   resp_o,
  output logic       resp_v_o
);

  logic [DATA_W-1:0]     mem [DRAM_WORDS];
  logic [DRAM_IDX_W-1:0] idx;
  logic                  wr_en;

  // word index from the low address bits
  assign idx   = req_i.addr[DRAM_IDX_W-1:0];
  assign wr_en = v_i && (req_i.op == OP_STORE);

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem[idx] <= req_i.data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else
      resp_v_o <= v_i;
  end

  // response goes back to whoever sent the request
  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      resp_o.op      <= req_i.op;
      resp_o.dst_x   <= req_i.src_x;
      resp_o.dst_y   <= req_i.src_y;
      resp_o.load_id <= req_i.load_id;
      if (req_i.op == OP_LOAD)
        resp_o.data <= mem[idx];
      else
        resp_o.data <= '0;
    end
  end

endmodule

// ==== hw/manycore_io_complex.sv ====
`timescale 1ns/100ps

module manycore_io_complex
  import manycore_io_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  // loader toward the array
  output mc_packet_t io_pkt_o,
  output logic       io_v_o,
  input  logic       io_ready_i,
  input  logic       io_credit_i,

  // tiles toward the io node
  input  mc_packet_t io_pkt_i,
  input  logic       io_v_i,
  output logic       io_credit_o,

  // vertical link
  input  mc_packet_t mem_req_i,
  input  logic       mem_v_i,
  output mc_resp_t   mem_resp_o,
  output logic       mem_resp_v_o,

  output logic       finish_o,
  output logic       success_o,
  output logic       timeout_o,
  output logic       load_done_o
);

  logic loader_v;
  logic send_ok;

  assign io_v_o = loader_v;

  spmd_loader loader (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .send_ok_i (send_ok),
    .pkt_o     (io_pkt_o),
    .v_o       (loader_v),
    .done_o    (load_done_o)
  );

  // loader only raises v under send_ok, so v alone marks a transfer
  out_credit_counter credits (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ready_i   (io_ready_i),
    .send_i    (loader_v),
    .credit_i  (io_credit_i),
    .send_ok_o (send_ok)
  );

  io_monitor monitor (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .pkt_i     (io_pkt_i),
    .v_i       (io_v_i),
    .credit_o  (io_credit_o),
    .finish_o  (finish_o),
    .success_o (success_o),
    .timeout_o (timeout_o)
  );

  dram_model dram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (mem_req_i),
    .v_i      (mem_v_i),
    .resp_o   (mem_resp_o),
    .resp_v_o (mem_resp_v_o)
  );

endmodule

// ==== dv/tb_manycore_io_complex.sv ====
`timescale 1ns/100ps

module tb_manycore_io_complex
  import manycore_io_pkg::*;
();

  localparam int LOAD_PKTS = NUM_TILES * (PROG_WORDS + 1);
  localparam int MEM_OPS   = 12;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       io_ready_i = 1'b0;
  logic       io_credit_i = 1'b0;
  logic       io_v_o, io_credit_o, io_v_i, mem_v_i, mem_resp_v_o;
  logic       finish_o, success_o, timeout_o, load_done_o;
  mc_packet_t io_pkt_o, io_pkt_i, mem_req_i;
  mc_resp_t   mem_resp_o;

  logic [DATA_W-1:0] prog_image [PROG_WORDS];
  logic [DATA_W-1:0] shadow [DRAM_WORDS];
  logic [31:0]       lcg_state = 32'd3;
  int                load_count = 0;
  int                credit_count = 0;
  logic              array_active = 1'b0;
  logic              credits_en = 1'b0;

  manycore_io_complex dut0 (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // image stores tile by tile, then one unfreeze store per tile
  function automatic mc_packet_t expected_load_pkt(input int n);
    mc_packet_t pkt;
    int         tile;
    pkt       = '0;
    pkt.op    = OP_STORE;
    pkt.src_x = IO_X_CORD;
    pkt.src_y = IO_Y_CORD;
    if (n < NUM_TILES * PROG_WORDS)
    begin
      tile     = n / PROG_WORDS;
      pkt.addr = PROG_BASE + ADDR_W'(n % PROG_WORDS);
      pkt.data = prog_image[n % PROG_WORDS];
    end
    else
    begin
      tile     = n - NUM_TILES * PROG_WORDS;
      pkt.addr = CSR_FREEZE_ADDR;
    end
    pkt.dst_x = X_W'(tile % NUM_TILES_X);
    pkt.dst_y = Y_W'(tile / NUM_TILES_X + 1);
    return pkt;
  endfunction

  // answer goes back to the requester with its op and load_id
  function automatic mc_resp_t mem_reply(input mc_packet_t req, input logic [DATA_W-1:0] data);
    mc_resp_t resp;
    resp.op      = req.op;
    resp.data    = data;
    resp.dst_x   = req.src_x;
    resp.dst_y   = req.src_y;
    resp.load_id = req.load_id;
    return resp;
  endfunction

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_pkt(input string name, input mc_packet_t got, input mc_packet_t exp);
    if (got !== exp)
      stop_with_error($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_resp(input string name, input mc_resp_t got, input mc_resp_t exp);
    if (got !== exp)
      stop_with_error($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  // one packet to the io node, credit comes back a cycle later
  task automatic send_io_pkt(input mc_packet_t pkt);
    @(posedge clk_i);
    io_pkt_i <= pkt;
    io_v_i   <= 1'b1;
    @(negedge clk_i);
    check_bit("io_credit_o", io_credit_o, 1'b0);
    @(posedge clk_i);
    io_v_i <= 1'b0;
    @(negedge clk_i);
    check_bit("io_credit_o", io_credit_o, 1'b1);
  endtask

  task automatic mem_access(input mc_packet_t req, input mc_resp_t exp);
    @(posedge clk_i);
    mem_req_i <= req;
    mem_v_i   <= 1'b1;
    @(negedge clk_i);
    check_bit("mem_resp_v_o", mem_resp_v_o, 1'b0);
    @(posedge clk_i);
    mem_v_i <= 1'b0;
    @(negedge clk_i);
    check_bit("mem_resp_v_o", mem_resp_v_o, 1'b1);
    check_resp("mem_resp_o", mem_resp_o, exp);
  endtask

  // array side with random ready stalls and late credit returns
  always @(posedge clk_i)
  begin
    logic [31:0] roll;
    roll = lcg_next();
    if (array_active)
    begin
      io_ready_i  <= (roll[1:0] != 2'b00);
      io_credit_i <= credits_en && (load_count > credit_count) && roll[2];
    end
    else
    begin
      io_ready_i  <= 1'b0;
      io_credit_i <= 1'b0;
    end
  end

  always @(negedge clk_i)
  begin
    if (rst_n_i && io_v_o)
    begin
      if (load_count >= LOAD_PKTS)
        stop_with_error("loader sent a packet after its last unfreeze store");
      else
      begin
        check_pkt("io_pkt_o", io_pkt_o, expected_load_pkt(load_count));
        check_bit("load_done_o", load_done_o, 1'b0);
      end
      load_count = load_count + 1;
    end
    if (rst_n_i && io_credit_i)
      credit_count = credit_count + 1;
  end

  initial
  begin
    mc_packet_t        req;
    logic [ADDR_W-1:0] addrs [MEM_OPS];
    logic [31:0]       r;
    int                cycles;
    int                i;
    rst_n_i   = 1'b0;
    io_v_i    = 1'b0;
    mem_v_i   = 1'b0;
    io_pkt_i  = '0;
    mem_req_i = '0;
    $readmemh(PROG_FILE, prog_image);
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // no credits come back yet, so the pool caps the sends
    @(negedge clk_i);
    array_active = 1'b1;
    cycles = 0;
    while (load_count < MAX_OUT_CREDITS)
    begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > 200)
        stop_with_error("timed out waiting for the loader to spend its credits");
    end
    // pool is empty, the loader has to stay quiet
    repeat (20)
    begin
      @(negedge clk_i);
      check_bit("io_v_o", io_v_o, 1'b0);
    end
    credits_en = 1'b1;

    cycles = 0;
    while (load_count < LOAD_PKTS)
    begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > 4000)
        stop_with_error("timed out waiting for the loader to send all packets");
    end
    @(negedge clk_i);
    check_bit("load_done_o", load_done_o, 1'b1);
    array_active = 1'b0;

    // random stores, then loads of the same addresses
    for (i = 0; i < 2 * MEM_OPS; i = i + 1)
    begin
      r           = lcg_next();
      req         = '0;
      req.src_x   = r[16];
      req.src_y   = r[17] ? 2'd2 : 2'd1;
      req.load_id = r[22:18];
      if (i < MEM_OPS)
      begin
        req.op   = OP_STORE;
        req.addr = r[ADDR_W-1:0];
        req.data = lcg_next();
        addrs[i] = req.addr;
        shadow[req.addr[DRAM_IDX_W-1:0]] = req.data;
        mem_access(req, mem_reply(req, '0));
      end
      else
      begin
        req.op   = OP_LOAD;
        req.addr = addrs[i - MEM_OPS];
        mem_access(req, mem_reply(req, shadow[req.addr[DRAM_IDX_W-1:0]]));
      end
    end

    req      = '0;
    req.op   = OP_LOAD;
    req.addr = 16'h0100;
    send_io_pkt(req);
    check_bit("finish_o", finish_o, 1'b0);
    req.op   = OP_STORE;
    req.addr = FINISH_ADDR;
    send_io_pkt(req);
    check_bit("finish_o", finish_o, 1'b1);
    check_bit("success_o", success_o, 1'b1);

    apply_reset();
    @(negedge clk_i);
    check_bit("finish_o", finish_o, 1'b0);
    check_bit("load_done_o", load_done_o, 1'b0);
    req.addr = FAIL_ADDR;
    send_io_pkt(req);
    check_bit("finish_o", finish_o, 1'b1);
    check_bit("success_o", success_o, 1'b0);

    // nobody finishes, the cycle limit has to trip
    apply_reset();
    cycles = 0;
    @(negedge clk_i);
    while (!timeout_o)
    begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES + 20)
        stop_with_error("timed out waiting for timeout_o to rise");
      @(negedge clk_i);
    end
    if (cycles != MAX_CYCLES)
      stop_with_error($sformatf("error at %0t: timeout_o rose after %0d cycles, expected %0d",
        $time, cycles, MAX_CYCLES));
    check_bit("finish_o", finish_o, 1'b0);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== build.f ====
hw/manycore_io_pkg.sv
hw/spmd_loader.sv
hw/out_credit_counter.sv
hw/io_monitor.sv
hw/dram_model.sv
hw/manycore_io_complex.sv
dv/tb_manycore_io_complex.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_manycore_io_complex
RTL_TOP    = manycore_io_complex
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== program.hex ====
// one 32-bit program word per line, word 0 first
00000093
00000113
000011b7
ad018193
00100213
00420233
fff28293
fe029ee3
00412023
0041a023
00000013
00000013
00000013
00000013
00000013
0000006f
